// ==== build.f ====
logic/frontend_pkg.sv
logic/fifo.sv
logic/fetch_fsm.sv
logic/inflight_counter.sv
logic/frontend_top.sv
verif/frontend_assertions.sv
verif/frontend_tb.sv

// ==== verif/frontend_tb.sv ====
// testbench for the fetch front end: clock, LFSR stimulus, memory model, reference model, timeout
`timescale 1ns/1ps

module frontend_tb import frontend_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int TRAFFIC_CYCLES = 2000;
    // QUEUE_DEPTH responses at up to 3 cycles each, then the pops, with margin
    localparam int DRAIN_CYCLES   = 8 * QUEUE_DEPTH;
    localparam int MAX_CYCLES     = RESET_CYCLES + TRAFFIC_CYCLES + DRAIN_CYCLES;

    logic          clk;
    logic          rst_n;
    redirect_t     redirect;
    logic          req_valid;
    logic          req_ready;
    addr_t         req_pc;
    logic          rsp_valid;
    instr_t        rsp_instr;
    logic          out_valid;
    logic          out_ready;
    fetch_packet_t out_packet;

    logic [15:0]   lfsr_q = 16'd58;

    // memory model, one entry per accepted request, oldest first
    addr_t         mem_addr[$];
    int            mem_due[$];
    int            mem_gen[$];
    int            last_due = 0;

    // reference model
    addr_t         exp_req_pc = RESET_PC;
    addr_t         exp_out_pc = RESET_PC;
    int            cur_gen = 0;
    // kept responses not yet taken by decode
    int            pending = 0;

    int            kept_count = 0;
    int            popped_count = 0;
    int            flushed_count = 0;
    int            redirect_count = 0;
    int            value_errors = 0;
    int            other_errors = 0;
    int            cyc = 0;
    int            run_cyc = 0;
    int            timeout_count = 0;
    bit            first_req_done = 1'b0;
    bit            draining = 1'b0;
    bit            drained = 1'b0;

    frontend_top frontend_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_pc     (req_pc),
        .rsp_valid  (rsp_valid),
        .rsp_instr  (rsp_instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic feedback;
        feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q   = {lfsr_q[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int unsigned width);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    task automatic end_run();
        $display("done: %0d value errors, %0d other errors, %0d packets, %0d redirects",
                 value_errors, other_errors, popped_count, redirect_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        logic  req_fire;
        logic  redir;
        logic  kept;
        int    delay;
        int    due;
        addr_t new_target;

        req_fire = req_valid && req_ready;
        redir    = redirect.valid;

        // quiet outputs during reset and in the IDLE cycle after it
        if ((!rst_n && cyc > 0) || (rst_n && run_cyc == 0)) begin
            assert (!req_valid) else begin
                value_errors++;
                $display("Error: req_valid = %h after reset, expected 0", req_valid);
            end
            assert (!out_valid) else begin
                value_errors++;
                $display("Error: out_valid = %h after reset, expected 0", out_valid);
            end
        end

        if (rst_n) begin
            if (redir) begin
                assert (!req_valid) else begin
                    value_errors++;
                    $display("Error: req_valid = %h in a redirect cycle, expected 0", req_valid);
                end
            end

            if (req_fire) begin
                assert (req_pc == exp_req_pc) else begin
                    value_errors++;
                    $display("Error: req_pc = %h, expected %h", req_pc, exp_req_pc);
                end
                delay = 1 + int'(random_bits(2)) % 3;
                due   = cyc + delay;
                // answers stay in request order
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                mem_addr.push_back(req_pc);
                mem_due.push_back(due);
                mem_gen.push_back(cur_gen);
                exp_req_pc     = exp_req_pc + PC_STEP;
                first_req_done = 1'b1;
            end

            if (rsp_valid) begin
                kept = (mem_gen[0] == cur_gen) && !redir;
                void'(mem_addr.pop_front());
                void'(mem_due.pop_front());
                void'(mem_gen.pop_front());
                if (kept) begin
                    pending++;
                    kept_count++;
                end
            end

            // a bypassed packet can leave in the cycle of its response
            if (out_valid && out_ready) begin
                assert (out_packet.pc == exp_out_pc) else begin
                    value_errors++;
                    $display("Error: out_packet.pc = %h, expected %h", out_packet.pc, exp_out_pc);
                end
                assert (out_packet.instr == ~exp_out_pc) else begin
                    value_errors++;
                    $display("Error: out_packet.instr = %h, expected %h",
                             out_packet.instr, ~exp_out_pc);
                end
                assert (pending > 0) else begin
                    other_errors++;
                    $display("decode took a packet that no kept response produced");
                end
                if (pending > 0) begin
                    pending--;
                end
                popped_count++;
                exp_out_pc = exp_out_pc + PC_STEP;
            end

            if (redir) begin
                exp_req_pc = redirect.target;
                exp_out_pc = redirect.target;
                flushed_count += pending;
                pending = 0;
                cur_gen++;
                redirect_count++;
            end

            assert (mem_addr.size() + pending <= QUEUE_DEPTH) else begin
                other_errors++;
                $display("%0d requests accepted and not yet popped, above the limit of %0d",
                         mem_addr.size() + pending, QUEUE_DEPTH);
            end

            if (mem_due.size() != 0 && mem_due[0] == cyc + 1) begin
                rsp_valid <= 1'b1;
                rsp_instr <= ~mem_addr[0];
            end else begin
                rsp_valid <= 1'b0;
                rsp_instr <= '0;
            end

            if (draining) begin
                req_ready <= 1'b0;
                out_ready <= 1'b1;
                redirect  <= '0;
            end else begin
                req_ready <= random_bits(2) != 0;
                // alternate stretches of heavy and light decode back-pressure
                if ((run_cyc / 256) % 2 == 1) begin
                    out_ready <= random_bits(2) == 0;
                end else begin
                    out_ready <= random_bits(2) != 0;
                end
                if (first_req_done && random_bits(6) == 0) begin
                    new_target = {4'h2, 26'(random_bits(26)), 2'b00};
                    redirect   <= '{valid: 1'b1, target: new_target};
                end else begin
                    redirect <= '0;
                end
            end

            drained <= draining && mem_addr.size() == 0 && pending == 0;
            run_cyc++;
        end
        cyc++;
    end

    initial begin
        rst_n     = 1'b0;
        redirect  = '0;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_instr = '0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (TRAFFIC_CYCLES) @(posedge clk);
        draining <= 1'b1;
        while (!drained) begin
            @(posedge clk);
        end
        assert (!out_valid) else begin
            value_errors++;
            $display("Error: out_valid = %h after the drain, expected 0", out_valid);
        end
        assert (popped_count + flushed_count == kept_count) else begin
            other_errors++;
            $display("%0d packets reached decode and %0d were flushed, but %0d responses were kept",
                     popped_count, flushed_count, kept_count);
        end
        assert (popped_count > 0) else begin
            other_errors++;
            $display("no packet reached decode");
        end
        end_run();
    end

    initial begin
        while (timeout_count < MAX_CYCLES) begin
            @(posedge clk);
            timeout_count++;
        end
        other_errors++;
        $display("timeout after %0d cycles, the front end did not drain", MAX_CYCLES);
        end_run();
    end

endmodule

// ==== verif/frontend_assertions.sv ====
// concurrent checks on the request handshake and the request credit
`timescale 1ns/1ps

module frontend_assertions import frontend_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    input logic         redirect_valid,
    input logic         req_valid,
    input logic         req_ready,
    input addr_t        req_pc,
    input cnt_t         reserved
);

    // a waiting request holds unless a redirect withdraws it
    property req_held;
        @(posedge clk) disable iff (!rst_n)
            (req_valid && !req_ready) ##1 !redirect_valid |-> req_valid && $stable(req_pc);
    endproperty

    property reserved_bounded;
        @(posedge clk) disable iff (!rst_n)
            reserved <= cnt_t'(QUEUE_DEPTH);
    endproperty

    assert property (req_held) else $error("request dropped or changed while waiting");
    assert property (reserved_bounded) else $error("reserved slots above the queue depth");

endmodule

bind frontend_top frontend_assertions frontend_assertions_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect.valid),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_pc         (req_pc),
    .reserved       (u_counter.reserved)
);

// ==== logic/frontend_top.sv ====
// fetch front end top: FSM, credit counter, address queue and packet queue
`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  redirect_t     redirect,
    output logic          req_valid,
    input  logic          req_ready,
    output addr_t         req_pc,
    input  logic          rsp_valid,
    input  instr_t        rsp_instr,
    output logic          out_valid,
    input  logic          out_ready,
    output fetch_packet_t out_packet
);

    logic  req_fire;
    logic  pop_fire;
    logic  credit_ok;
    cnt_t  outstanding;
    logic  rsp_keep;
    // address of the oldest kept request
    addr_t head_pc;

    assign req_fire = req_valid && req_ready;
    assign pop_fire = out_valid && out_ready;

    fetch_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_pc      (req_pc),
        .rsp_valid   (rsp_valid),
        .credit_ok   (credit_ok),
        .outstanding (outstanding),
        .rsp_keep    (rsp_keep)
    );

    inflight_counter u_counter (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_fire       (req_fire),
        .rsp_valid      (rsp_valid),
        .pop_fire       (pop_fire),
        .redirect_valid (redirect.valid),
        .outstanding    (outstanding),
        .credit_ok      (credit_ok)
    );

    // credit keeps both queues from filling, so their ready is not needed
    fifo #(
        .T      (addr_t),
        .DEPTH  (QUEUE_DEPTH),
        .BYPASS (1'b1)
    ) addr_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect.valid),
        .in_valid  (req_fire),
        .in_ready  (),
        .in_data   (req_pc),
        .out_valid (),
        .out_ready (rsp_keep),
        .out_data  (head_pc)
    );

    fifo #(
        .T      (fetch_packet_t),
        .DEPTH  (QUEUE_DEPTH),
        .BYPASS (1'b1)
    ) packet_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect.valid),
        .in_valid  (rsp_keep),
        .in_ready  (),
        .in_data   ({head_pc, rsp_instr}),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_packet)
    );

endmodule

// ==== logic/inflight_counter.sv ====
// outstanding request count, reserved queue slots and request credit
`timescale 1ns/1ps

module inflight_counter import frontend_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic req_fire,
    input  logic rsp_valid,
    input  logic pop_fire,
    input  logic redirect_valid,
    output cnt_t outstanding,
    output logic credit_ok
);

    cnt_t outstanding_q;
    cnt_t outstanding_n;
    cnt_t reserved;
    cnt_t reserved_n;

    // responses of a flushed stream still to come
    cnt_t drop_q;
    cnt_t drop_n;
    logic drop_fire;

    assign drop_fire     = rsp_valid && (drop_q != '0);
    assign outstanding_n = outstanding_q + cnt_t'(req_fire) - cnt_t'(rsp_valid);

    always_comb begin
        reserved_n = reserved + cnt_t'(req_fire) - cnt_t'(pop_fire) - cnt_t'(drop_fire);
        drop_n     = drop_q - cnt_t'(drop_fire);
        // packet queue is flushed, only the old responses keep their slots
        if (redirect_valid) begin
            reserved_n = outstanding_n;
            drop_n     = outstanding_n;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding_q <= '0;
            reserved      <= '0;
            drop_q        <= '0;
        end else begin
            outstanding_q <= outstanding_n;
            reserved      <= reserved_n;
            drop_q        <= drop_n;
        end
    end

    assign outstanding = outstanding_q;
    assign credit_ok   = reserved < cnt_t'(QUEUE_DEPTH);

endmodule

// ==== logic/fetch_fsm.sv ====
// fetch FSM: fetch address, request issue and response filtering around redirects
`timescale 1ns/1ps

module fetch_fsm import frontend_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  redirect_t redirect,
    output logic      req_valid,
    input  logic      req_ready,
    output addr_t     req_pc,
    input  logic      rsp_valid,
    input  logic      credit_ok,
    input  cnt_t      outstanding,
    output logic      rsp_keep
);

    fetch_state_t state_q;
    fetch_state_t state_n;
    addr_t        pc_q;
    addr_t        pc_n;

    logic         req_fire;
    // requests still in flight once this cycle's response is counted
    cnt_t         remaining;

    // credit only falls after a transfer, so a waiting request stays up
    assign req_valid = (state_q == FETCH) && credit_ok && !redirect.valid;
    assign req_fire  = req_valid && req_ready;
    assign req_pc    = pc_q;

    // a response in the redirect cycle belongs to the old stream
    assign rsp_keep  = rsp_valid && (state_q == FETCH) && !redirect.valid;

    assign remaining = outstanding - cnt_t'(rsp_valid);

    always_comb begin
        state_n = state_q;
        pc_n    = pc_q;
        if (redirect.valid) begin
            pc_n    = redirect.target;
            state_n = (remaining != '0) ? DRAIN : FETCH;
        end else begin
            case (state_q)
                IDLE: begin
                    state_n = FETCH;
                end
                FETCH: begin
                    if (req_fire) begin
                        pc_n = pc_q + PC_STEP;
                    end
                end
                DRAIN: begin
                    // old responses all back
                    if (remaining == '0) begin
                        state_n = FETCH;
                    end
                end
                default: begin
                    state_n = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_n;
            pc_q    <= pc_n;
        end
    end

endmodule

// ==== logic/fifo.sv ====
// generic FIFO with registered handshake, optional empty bypass and flush
`timescale 1ns/1ps

module fifo #(
    parameter type         T      = logic [31:0],
    parameter int unsigned DEPTH  = 8,
    parameter bit          BYPASS = 1'b1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    logic   push;
    logic   pop;

    ptr_t   wptr_q;
    ptr_t   wptr_n;
    ptr_t   rptr_q;
    ptr_t   rptr_n;
    count_t cnt_q;
    count_t cnt_n;

    logic   ready_q;
    logic   valid_q;
    // set while empty, output then follows the input
    logic   empty_q;

    T       mem [DEPTH];
    T       head_n;
    T       head_q;
    logic   head_from_input;

    // a push in the flush cycle is lost
    assign push = in_valid && ready_q && !flush;
    assign pop  = out_valid && out_ready;

    always_comb begin
        wptr_n = wptr_q;
        rptr_n = rptr_q;
        if (push) begin
            wptr_n = (wptr_q == ptr_t'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
        end
        if (pop) begin
            rptr_n = (rptr_q == ptr_t'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
        end
        if (flush) begin
            wptr_n = '0;
            rptr_n = '0;
        end
    end

    assign cnt_n = flush ? '0 : cnt_q + count_t'(push) - count_t'(pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            cnt_q   <= '0;
            ready_q <= 1'b0;
            valid_q <= 1'b0;
            empty_q <= 1'b0;
        end else begin
            wptr_q  <= wptr_n;
            rptr_q  <= rptr_n;
            cnt_q   <= cnt_n;
            ready_q <= cnt_n < DEPTH;
            valid_q <= cnt_n != '0;
            empty_q <= BYPASS && (cnt_n == '0);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr_q] <= in_data;
        end
    end

    // next head is the incoming word when nothing else stays behind
    assign head_from_input = push && (cnt_q == count_t'(pop));
    assign head_n          = head_from_input ? in_data : mem[rptr_n];

    always_ff @(posedge clk) begin
        head_q <= head_n;
    end

    assign in_ready  = ready_q;
    assign out_valid = empty_q ? (in_valid && !flush) : valid_q;
    assign out_data  = empty_q ? in_data : head_q;

endmodule

// ==== logic/frontend_pkg.sv ====
// fetch front end widths, queue depth, reset address, payload structs and FSM states
package frontend_pkg;

    // address and instruction words
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // request and slot counts, 0 to QUEUE_DEPTH
    typedef logic [3:0] cnt_t;

    // entries per FIFO, also the request credit limit
    localparam int unsigned QUEUE_DEPTH = 8;

    localparam addr_t RESET_PC = 32'h0000_1000;
    localparam addr_t PC_STEP  = 32'd4;

    // one-cycle redirect strobe with its target
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // what decode receives
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_packet_t;

    // IDLE only for the cycle after reset
    // DRAIN waits for the responses of a flushed stream
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } fetch_state_t;

endpackage
